// ==== hw/aib_bitsync.sv ====
module aib_bitsync
   import aib_cal_pkg::*;
#(
   parameter int SYNC_STAGES = sync_stages_default
)
(
   input  logic clk_in,
   input  logic reset_n_sync,
   input  logic data_in,       // Asynchronous level
   output logic data_out       // Level in clk_in domain
);

   logic [SYNC_STAGES-1:0] sync_q; // Bit 0 samples data_in

   always_ff @(posedge clk_in or negedge reset_n_sync)
   begin
      if (!reset_n_sync)
      begin
         sync_q <= '0;
      end
      else
      begin
         sync_q <= {sync_q[SYNC_STAGES-2:0], data_in};
      end
   end

   assign data_out = sync_q[SYNC_STAGES-1];

   // Fewer than two stages gives no metastability settling time
   a_min_stages : assert property (@(posedge clk_in) disable iff (!reset_n_sync)
      SYNC_STAGES >= 2)
      else $error("aib_bitsync needs at least 2 stages, got %0d", SYNC_STAGES);

endmodule

// ==== hw/aib_cal_pkg.sv ====
package aib_cal_pkg;

   // ====================
   // Parameter defaults
   // ====================

   // Flops in each request synchronizer
   parameter int sync_stages_default = 2;

   // DLL lock time in clk_in cycles
   parameter int lock_cycles_default = 16;

   // ====================
   // Sequencer states
   // ====================

   typedef enum logic [1:0]
   {
      st_idle = 2'b00, // Waiting for cal_en
      st_dcc  = 2'b01, // DCC lock request up
      st_dll  = 2'b10, // DLL lock request up
      st_done = 2'b11  // Channel calibrated
   } cal_state_t;

endpackage

// ==== hw/aib_cal_seq.sv ====
module aib_cal_seq
   import aib_cal_pkg::*;
(
   input  logic clk_in,
   input  logic reset_n_sync,
   input  logic cal_en,            // Channel calibration enable
   input  logic ms_dcc_cal_done,
   input  logic sl_dcc_cal_done,
   input  logic dll_lock,
   output logic dcc_lock_req,
   output logic dll_lock_req,
   output logic cal_done
);

   cal_state_t state;
   cal_state_t state_nxt;
   logic       dcc_done_any;

   // Role is resolved in the DCC, so either done will do
   assign dcc_done_any = ms_dcc_cal_done || sl_dcc_cal_done;

   // ====================
   // Next state
   // ====================

   always_comb
   begin
      state_nxt = state;
      if (!cal_en)
      begin
         state_nxt = st_idle; // Withdrawal from any state
      end
      else
      begin
         case (state)
            st_idle:
            begin
               state_nxt = st_dcc;
            end
            st_dcc:
            begin
               if (dcc_done_any)
               begin
                  state_nxt = st_dll;
               end
            end
            st_dll:
            begin
               if (dll_lock)
               begin
                  state_nxt = st_done;
               end
            end
            st_done:
            begin
               state_nxt = st_done;
            end
            default:
            begin
               state_nxt = st_idle;
            end
         endcase
      end
   end

   // ====================
   // State and outputs
   // ====================

   // Outputs decoded from next state so they change with the state
   always_ff @(posedge clk_in or negedge reset_n_sync)
   begin
      if (!reset_n_sync)
      begin
         state        <= st_idle;
         dcc_lock_req <= 1'b0;
         dll_lock_req <= 1'b0;
         cal_done     <= 1'b0;
      end
      else
      begin
         state        <= state_nxt;
         dcc_lock_req <= (state_nxt != st_idle);
         dll_lock_req <= (state_nxt == st_dll) || (state_nxt == st_done);
         cal_done     <= (state_nxt == st_done);
      end
   end

   // DLL lock drops a cycle after cal_done, never before
   a_done_lock : assert property (@(posedge clk_in) disable iff (!reset_n_sync)
      cal_done |-> dll_lock);

endmodule

// ==== hw/aib_cal_top.sv ====
module aib_cal_top
   import aib_cal_pkg::*;
#(
   parameter int SYNC_STAGES = sync_stages_default,
   parameter int LOCK_CYCLES = lock_cycles_default
)
(
   input  logic clk_in,
   input  logic reset_n_sync,     // Already synchronized to clk_in
   input  logic cal_en,
   input  logic ms_nsl,
   input  logic ms_dcc_cal_req,
   input  logic sl_dcc_cal_req,
   output logic cal_done,
   output logic ms_dcc_cal_done,
   output logic sl_dcc_cal_done,
   output logic dll_lock,
   output logic clk_dcc
);

   logic dcc_lock_req;
   logic dll_lock_req;

   aib_cal_seq i_cal_seq
   (
      .clk_in          (clk_in),
      .reset_n_sync    (reset_n_sync),
      .cal_en          (cal_en),
      .ms_dcc_cal_done (ms_dcc_cal_done),
      .sl_dcc_cal_done (sl_dcc_cal_done),
      .dll_lock        (dll_lock),
      .dcc_lock_req    (dcc_lock_req),
      .dll_lock_req    (dll_lock_req),
      .cal_done        (cal_done)
   );

   aib_dcc #(.SYNC_STAGES(SYNC_STAGES)) i_dcc
   (
      .clk_in          (clk_in),
      .reset_n_sync    (reset_n_sync),
      .ms_nsl          (ms_nsl),
      .dcc_lock_req    (dcc_lock_req),
      .ms_dcc_cal_req  (ms_dcc_cal_req),
      .sl_dcc_cal_req  (sl_dcc_cal_req),
      .ms_dcc_cal_done (ms_dcc_cal_done),
      .sl_dcc_cal_done (sl_dcc_cal_done),
      .clk_dcc         (clk_dcc)
   );

   // DLL runs on the DCC output clock
   aib_dll #(.LOCK_CYCLES(LOCK_CYCLES)) i_dll
   (
      .clk_dcc      (clk_dcc),
      .reset_n_sync (reset_n_sync),
      .dll_lock_req (dll_lock_req),
      .dll_lock     (dll_lock)
   );

endmodule

// ==== hw/aib_dcc.sv ====
module aib_dcc
   import aib_cal_pkg::*;
#(
   parameter int SYNC_STAGES = sync_stages_default
)
(
   input  logic clk_in,
   input  logic reset_n_sync,
   input  logic ms_nsl,           // High selects master role
   input  logic dcc_lock_req,     // Feeds both tx and rx lock requests
   input  logic ms_dcc_cal_req,   // From adapter, asynchronous
   input  logic sl_dcc_cal_req,   // From adapter, asynchronous
   output logic ms_dcc_cal_done,
   output logic sl_dcc_cal_done,
   output logic clk_dcc
);

   logic ms_dcc_cal_req_sync;
   logic sl_dcc_cal_req_sync;
   logic ms_done_nxt;
   logic sl_done_nxt;

   // No real correction, clock passes straight through
   assign clk_dcc = clk_in;

   aib_bitsync #(.SYNC_STAGES(SYNC_STAGES)) i_ms_req_sync
   (
      .clk_in       (clk_in),
      .reset_n_sync (reset_n_sync),
      .data_in      (ms_dcc_cal_req),
      .data_out     (ms_dcc_cal_req_sync)
   );

   aib_bitsync #(.SYNC_STAGES(SYNC_STAGES)) i_sl_req_sync
   (
      .clk_in       (clk_in),
      .reset_n_sync (reset_n_sync),
      .data_in      (sl_dcc_cal_req),
      .data_out     (sl_dcc_cal_req_sync)
   );

   // Lock request low wins, otherwise set on role match and hold
   assign ms_done_nxt = !dcc_lock_req ? 1'b0 :
                        (ms_nsl && ms_dcc_cal_req_sync) ? 1'b1 : ms_dcc_cal_done;
   assign sl_done_nxt = !dcc_lock_req ? 1'b0 :
                        (!ms_nsl && sl_dcc_cal_req_sync) ? 1'b1 : sl_dcc_cal_done;

   always_ff @(posedge clk_in or negedge reset_n_sync)
   begin
      if (!reset_n_sync)
      begin
         ms_dcc_cal_done <= 1'b0;
         sl_dcc_cal_done <= 1'b0;
      end
      else
      begin
         ms_dcc_cal_done <= ms_done_nxt;
         sl_dcc_cal_done <= sl_done_nxt;
      end
   end

   // Only one role can ever be calibrated
   a_one_role : assert property (@(posedge clk_in) disable iff (!reset_n_sync)
      !(ms_dcc_cal_done && sl_dcc_cal_done));

   // Done needs the sequencer request on the edge before
   a_done_req : assert property (@(posedge clk_in) disable iff (!reset_n_sync)
      (ms_dcc_cal_done || sl_dcc_cal_done) |-> $past(dcc_lock_req));

endmodule

// ==== hw/aib_dll.sv ====
module aib_dll
   import aib_cal_pkg::*;
#(
   parameter int LOCK_CYCLES = lock_cycles_default
)
(
   input  logic clk_dcc,
   input  logic reset_n_sync,
   input  logic dll_lock_req,
   output logic dll_lock
);

   // Counter saturates at LOCK_CYCLES
   localparam int CNT_W = $clog2(LOCK_CYCLES + 1);

   logic [CNT_W-1:0] lock_cnt;
   logic             cnt_full;

   assign cnt_full = (lock_cnt == CNT_W'(LOCK_CYCLES));

   // ====================
   // Lock counter
   // ====================

   always_ff @(posedge clk_dcc or negedge reset_n_sync)
   begin
      if (!reset_n_sync)
      begin
         lock_cnt <= '0;
         dll_lock <= 1'b0;
      end
      else if (!dll_lock_req)
      begin
         lock_cnt <= '0;   // Request withdrawn, start over
         dll_lock <= 1'b0;
      end
      else
      begin
         if (!cnt_full)
         begin
            lock_cnt <= lock_cnt + 1'b1;
         end
         dll_lock <= cnt_full; // Held while count stays saturated
      end
   end

   // Lock is only reported while the sequencer still asks for it
   a_lock_req : assert property (@(posedge clk_dcc) disable iff (!reset_n_sync)
      dll_lock |-> $past(dll_lock_req));

endmodule

// ==== sim/aib_cal_clkgen.sv ====
module aib_cal_clkgen
#(
   parameter real CLK_PERIOD   = 8.0,
   parameter int  RESET_CYCLES = 16
)
(
   input  logic reset_req,      // Extra reset pulse during the test
   output logic clk_in,
   output logic reset_n_sync
);

   timeunit 1ns;
   timeprecision 100ps;

   logic por_n;

   initial
   begin
      clk_in = 1'b0;
      forever
         #(CLK_PERIOD / 2.0) clk_in = ~clk_in;
   end

   // Power-on reset, released on a rising edge
   initial
   begin
      por_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_in);
      por_n <= 1'b1;
   end

   assign reset_n_sync = por_n && !reset_req;

endmodule

// ==== sim/aib_cal_tb.sv ====
module aib_cal_tb
   import aib_cal_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int SYNC_STAGES  = sync_stages_default;
   localparam int LOCK_CYCLES  = lock_cycles_default;
   localparam int NUM_ENTRIES  = 8;
   localparam int DONE_TIMEOUT = 200;
   localparam int IDLE_WINDOW  = 60;  // Well past 3 + 1 + LOCK_CYCLES + 1
   localparam int RST_TIMEOUT  = 40;

   logic clk_in;
   logic reset_n_sync;
   logic reset_req;
   logic cal_en;
   logic ms_nsl;
   logic ms_dcc_cal_req;
   logic sl_dcc_cal_req;
   logic cal_done;
   logic ms_dcc_cal_done;
   logic sl_dcc_cal_done;
   logic dll_lock;
   logic clk_dcc;

   // ====================
   // Stimulus table
   // ====================

   string tbl_name      [NUM_ENTRIES];
   logic  tbl_ms_nsl    [NUM_ENTRIES];
   logic  tbl_ms_req    [NUM_ENTRIES];
   logic  tbl_sl_req    [NUM_ENTRIES];
   logic  tbl_req_first [NUM_ENTRIES]; // Adapter request before cal_en
   logic  tbl_mid_reset [NUM_ENTRIES]; // Reset pulse after calibration
   logic  tbl_exp_ms    [NUM_ENTRIES];
   logic  tbl_exp_sl    [NUM_ENTRIES];
   logic  tbl_exp_cal   [NUM_ENTRIES];

   integer seed;

   aib_cal_clkgen i_clkgen
   (
      .reset_req    (reset_req),
      .clk_in       (clk_in),
      .reset_n_sync (reset_n_sync)
   );

   aib_cal_top #(.SYNC_STAGES(SYNC_STAGES), .LOCK_CYCLES(LOCK_CYCLES)) i_dut
   (
      .clk_in          (clk_in),
      .reset_n_sync    (reset_n_sync),
      .cal_en          (cal_en),
      .ms_nsl          (ms_nsl),
      .ms_dcc_cal_req  (ms_dcc_cal_req),
      .sl_dcc_cal_req  (sl_dcc_cal_req),
      .cal_done        (cal_done),
      .ms_dcc_cal_done (ms_dcc_cal_done),
      .sl_dcc_cal_done (sl_dcc_cal_done),
      .dll_lock        (dll_lock),
      .clk_dcc         (clk_dcc)
   );

   task automatic set_entry(input int idx, input string name, input logic role,
                            input logic ms_req, input logic sl_req, input logic req_first,
                            input logic mid_reset, input logic exp_ms, input logic exp_sl,
                            input logic exp_cal);
      tbl_name[idx]      = name;
      tbl_ms_nsl[idx]    = role;
      tbl_ms_req[idx]    = ms_req;
      tbl_sl_req[idx]    = sl_req;
      tbl_req_first[idx] = req_first;
      tbl_mid_reset[idx] = mid_reset;
      tbl_exp_ms[idx]    = exp_ms;
      tbl_exp_sl[idx]    = exp_sl;
      tbl_exp_cal[idx]   = exp_cal;
   endtask

   task automatic load_table();
      //        name                 role msr slr 1st rst  ems esl ecal
      set_entry(0, "master_cal",      1, 1, 0, 1, 0, 1, 0, 1);
      set_entry(1, "slave_cal",       0, 0, 1, 1, 0, 0, 1, 1);
      set_entry(2, "wrong_role_ms",   1, 0, 1, 1, 0, 0, 0, 0);
      set_entry(3, "wrong_role_sl",   0, 1, 0, 1, 0, 0, 0, 0);
      set_entry(4, "master_en_first", 1, 1, 0, 0, 0, 1, 0, 1);
      set_entry(5, "slave_en_first",  0, 0, 1, 0, 0, 0, 1, 1);
      set_entry(6, "master_reset",    1, 1, 0, 1, 1, 1, 0, 1);
      set_entry(7, "slave_reset",     0, 0, 1, 0, 1, 0, 1, 1);
   endtask

   // ====================
   // Checking
   // ====================

   task automatic check_value(input string test_name, input string sig_name,
                              input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("ERROR %s: %s expected %0b, actual %0b",
                  test_name, sig_name, expected, actual);
         $display("Verification failed");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic report_timeout(input string test_name, input string what, input int limit);
      $display("Test %s: %s did not happen within %0d cycles", test_name, what, limit);
      $display("Verification failed");
      $fatal(1, "Stopped on timeout");
   endtask

   // Sampled on the falling edge, away from the driving edge
   task automatic check_outputs(input string test_name, input logic exp_ms,
                                input logic exp_sl, input logic exp_dll, input logic exp_cal);
      check_value(test_name, "ms_dcc_cal_done", exp_ms, ms_dcc_cal_done);
      check_value(test_name, "sl_dcc_cal_done", exp_sl, sl_dcc_cal_done);
      check_value(test_name, "dll_lock", exp_dll, dll_lock);
      check_value(test_name, "cal_done", exp_cal, cal_done);
   endtask

   // Passthrough clock, sampled just after each edge
   task automatic probe_clk_dcc(input string test_name);
      @(posedge clk_in);
      #1;
      check_value(test_name, "clk_dcc high phase", 1'b1, clk_dcc);
      @(negedge clk_in);
      #1;
      check_value(test_name, "clk_dcc low phase", 1'b0, clk_dcc);
   endtask

   task automatic wait_for_reset_release();
      int cycles;
      cycles = 0;
      while (reset_n_sync !== 1'b1)
      begin
         if (cycles == RST_TIMEOUT)
            report_timeout("reset", "reset release", RST_TIMEOUT);
         cycles++;
         @(negedge clk_in);
      end
   endtask

   // Wrong role must stay low all the way to cal_done
   task automatic wait_for_cal_done(input int idx);
      int cycles;
      cycles = 0;
      @(negedge clk_in);
      while (cal_done !== 1'b1)
      begin
         if (!tbl_exp_ms[idx])
            check_value(tbl_name[idx], "ms_dcc_cal_done", 1'b0, ms_dcc_cal_done);
         if (!tbl_exp_sl[idx])
            check_value(tbl_name[idx], "sl_dcc_cal_done", 1'b0, sl_dcc_cal_done);
         if (cycles == DONE_TIMEOUT)
            report_timeout(tbl_name[idx], "cal_done", DONE_TIMEOUT);
         cycles++;
         @(negedge clk_in);
      end
   endtask

   task automatic watch_idle_window(input int idx);
      repeat (IDLE_WINDOW)
      begin
         @(negedge clk_in);
         check_outputs(tbl_name[idx], 1'b0, 1'b0, 1'b0, 1'b0);
      end
   endtask

   // ====================
   // One table entry
   // ====================

   task automatic run_entry(input int idx);
      int delay;
      delay = $unsigned($random(seed)) % 8;
      @(posedge clk_in);
      ms_nsl <= tbl_ms_nsl[idx];
      if (tbl_req_first[idx])
      begin
         ms_dcc_cal_req <= tbl_ms_req[idx];
         sl_dcc_cal_req <= tbl_sl_req[idx];
         repeat (delay) @(posedge clk_in);
         cal_en <= 1'b1;
      end
      else
      begin
         cal_en <= 1'b1;
         repeat (delay) @(posedge clk_in);
         ms_dcc_cal_req <= tbl_ms_req[idx];
         sl_dcc_cal_req <= tbl_sl_req[idx];
      end

      if (tbl_exp_cal[idx])
      begin
         wait_for_cal_done(idx);
         check_outputs(tbl_name[idx], tbl_exp_ms[idx], tbl_exp_sl[idx], 1'b1, 1'b1);
         if (tbl_mid_reset[idx])
         begin
            @(posedge clk_in);
            reset_req <= 1'b1;
            @(negedge clk_in);
            check_outputs(tbl_name[idx], 1'b0, 1'b0, 1'b0, 1'b0);
            probe_clk_dcc(tbl_name[idx]); // Clock keeps running through reset
            repeat (2) @(posedge clk_in);
            reset_req <= 1'b0; // cal_en and request still up, so it recalibrates
            wait_for_cal_done(idx);
            check_outputs(tbl_name[idx], tbl_exp_ms[idx], tbl_exp_sl[idx], 1'b1, 1'b1);
         end
      end
      else
      begin
         watch_idle_window(idx);
      end

      // Withdrawal, everything back low within 3 cycles
      @(posedge clk_in);
      cal_en         <= 1'b0;
      ms_dcc_cal_req <= 1'b0;
      sl_dcc_cal_req <= 1'b0;
      repeat (3) @(posedge clk_in);
      @(negedge clk_in);
      check_outputs(tbl_name[idx], 1'b0, 1'b0, 1'b0, 1'b0);
   endtask

   initial
   begin
      seed           = 33;
      reset_req      = 1'b0;
      cal_en         = 1'b0;
      ms_nsl         = 1'b0;
      ms_dcc_cal_req = 1'b0;
      sl_dcc_cal_req = 1'b0;
      load_table();

      wait_for_reset_release();
      check_outputs("after_reset", 1'b0, 1'b0, 1'b0, 1'b0);
      probe_clk_dcc("after_reset");

      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         run_entry(i);
      end

      $display("Verification passed");
      $finish;
   end

endmodule

// ==== verilog.f ====
hw/aib_cal_pkg.sv
hw/aib_bitsync.sv
hw/aib_dcc.sv
hw/aib_dll.sv
hw/aib_cal_seq.sv
hw/aib_cal_top.sv
sim/aib_cal_clkgen.sv
sim/aib_cal_tb.sv
